//--- verilog.f
verilog/csr_pkg.sv
verilog/csr_wdata_gen.sv
verilog/csr_regfile.sv
verilog/trap_ctrl.sv
verilog/csr_unit.sv
tests/tb_clock.sv
tests/csr_checker.sv
tests/tb_csr_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_csr_unit -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_csr_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  echo "failure reported in $LOG"
  exit 1
fi
exit 0

//--- tests/tb_csr_unit.sv
`default_nettype none

module tb_csr_unit;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum int {
    K_ACCESS, K_READ, K_RETIRE, K_CYCLE, K_IRQ, K_MRET, K_WFI_WAKE, K_WFI_TRAP
  } kind_e;

  localparam int TIMEOUT = 40;
  localparam logic [31:0] MSTATUS_MASK = (32'd1 << csr_pkg::MSTATUS_MIE) |
                                         (32'd1 << csr_pkg::MSTATUS_MPIE) |
                                         (32'd3 << csr_pkg::MSTATUS_MPP);
  localparam logic [31:0] MIE_MASK  = 32'd1 << csr_pkg::MEIE;
  localparam logic [31:0] MEPC_MASK = 32'hFFFF_FFFC;
  localparam logic [31:0] MEIP_BIT  = 32'd1 << csr_pkg::MEIP;

  logic clk;
  logic rstn;
  logic csr_valid;
  csr_pkg::csr_op_e csr_op;
  logic [11:0] csr_addr;
  logic [31:0] csr_src;
  logic [31:0] pc;
  logic retire;
  logic mret;
  logic wfi;
  logic irq;
  logic [31:0] csr_rdata;
  logic redirect;
  logic [31:0] redirect_pc;
  logic stall;

  // Stimulus table, one column per field
  string            t_name[$];
  kind_e            t_kind[$];
  csr_pkg::csr_op_e t_op[$];
  logic [11:0]      t_addr[$];
  logic [31:0]      t_src[$];
  bit               t_rand[$];
  logic [31:0]      t_exp[$];

  // Expected CSR contents
  logic [31:0] m_mstatus = '0;
  logic [31:0] m_mie     = '0;
  logic [31:0] m_mepc    = '0;
  int unsigned lcg_state = 5;

  tb_clock clk0 (.clk(clk), .rstn(rstn));

  csr_unit dut0 (
    .clk           (clk),
    .rstn          (rstn),
    .csr_valid_i   (csr_valid),
    .csr_op_i      (csr_op),
    .csr_addr_i    (csr_addr),
    .csr_src_i     (csr_src),
    .pc_i          (pc),
    .retire_i      (retire),
    .mret_i        (mret),
    .wfi_i         (wfi),
    .irq_i         (irq),
    .csr_rdata_o   (csr_rdata),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .stall_o       (stall)
  );

  csr_checker chk0 (
    .clk           (clk),
    .rstn          (rstn),
    .rdata_i       (csr_rdata),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .stall_i       (stall)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] addr);
    case (addr)
      csr_pkg::CSR_MSTATUS: return m_mstatus;
      csr_pkg::CSR_MIE:     return m_mie;
      csr_pkg::CSR_MEPC:    return m_mepc;
      csr_pkg::CSR_MTVEC:   return csr_pkg::MTVEC_BASE;
      default:              return 32'd0;
    endcase
  endfunction

  task automatic model_write(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                             input logic [31:0] src);
    logic [31:0] old;
    logic [31:0] val;
    old = model_read(addr);
    case (op)
      csr_pkg::CSR_OP_RS: val = old | src;
      csr_pkg::CSR_OP_RC: val = old & ~src;
      default:            val = src;
    endcase
    // Only the writable bits take the new value
    case (addr)
      csr_pkg::CSR_MSTATUS: m_mstatus = (old & ~MSTATUS_MASK) | (val & MSTATUS_MASK);
      csr_pkg::CSR_MIE:     m_mie = (old & ~MIE_MASK) | (val & MIE_MASK);
      csr_pkg::CSR_MEPC:    m_mepc = (old & ~MEPC_MASK) | (val & MEPC_MASK);
      default: ;
    endcase
  endtask

  task automatic model_trap(input logic [31:0] ret_pc);
    m_mepc = ret_pc & MEPC_MASK;
    m_mstatus[csr_pkg::MSTATUS_MPIE] = m_mstatus[csr_pkg::MSTATUS_MIE];
    m_mstatus[csr_pkg::MSTATUS_MIE] = 1'b0;
    m_mstatus[csr_pkg::MSTATUS_MPP +: 2] = 2'b11;
  endtask

  task automatic model_mret();
    m_mstatus[csr_pkg::MSTATUS_MIE] = m_mstatus[csr_pkg::MSTATUS_MPIE];
    m_mstatus[csr_pkg::MSTATUS_MPIE] = 1'b1;
    m_mstatus[csr_pkg::MSTATUS_MPP +: 2] = 2'b11;
  endtask

  task automatic add_entry(input string name, input kind_e kind, input csr_pkg::csr_op_e op,
                           input logic [11:0] addr, input logic [31:0] src, input bit rnd,
                           input logic [31:0] exp);
    t_name.push_back(name);
    t_kind.push_back(kind);
    t_op.push_back(op);
    t_addr.push_back(addr);
    t_src.push_back(src);
    t_rand.push_back(rnd);
    t_exp.push_back(exp);
  endtask

  task automatic load_table();
    add_entry("mstatus_rw", K_ACCESS, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MSTATUS, 0, 1'b1, 0);
    add_entry("mstatus_rs", K_ACCESS, csr_pkg::CSR_OP_RS, csr_pkg::CSR_MSTATUS, 0, 1'b1, 0);
    add_entry("mstatus_rc", K_ACCESS, csr_pkg::CSR_OP_RC, csr_pkg::CSR_MSTATUS, 0, 1'b1, 0);
    add_entry("mstatus_rs_zero", K_ACCESS, csr_pkg::CSR_OP_RS, csr_pkg::CSR_MSTATUS, 0, 1'b0, 0);
    add_entry("mie_rw", K_ACCESS, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MIE, 0, 1'b1, 0);
    add_entry("mie_rc_zero", K_ACCESS, csr_pkg::CSR_OP_RC, csr_pkg::CSR_MIE, 0, 1'b0, 0);
    add_entry("mepc_rw", K_ACCESS, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MEPC, 0, 1'b1, 0);
    add_entry("mepc_rs", K_ACCESS, csr_pkg::CSR_OP_RS, csr_pkg::CSR_MEPC, 0, 1'b1, 0);
    add_entry("mepc_rc", K_ACCESS, csr_pkg::CSR_OP_RC, csr_pkg::CSR_MEPC, 0, 1'b1, 0);
    add_entry("unknown_write", K_ACCESS, csr_pkg::CSR_OP_RW, 12'h7C0, 0, 1'b1, 0);
    add_entry("mvendorid", K_READ, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MVENDORID, 0, 1'b0, 0);
    add_entry("marchid", K_READ, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MARCHID, 0, 1'b0, 0);
    add_entry("mimpid", K_READ, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MIMPID, 0, 1'b0, 0);
    add_entry("mhartid", K_READ, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MHARTID, 0, 1'b0, 0);
    add_entry("mtvec", K_READ, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MTVEC, 0, 1'b0,
              csr_pkg::MTVEC_BASE);
    add_entry("minstret", K_RETIRE, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MINSTRET, 7, 1'b0, 7);
    add_entry("mcycle_delta", K_CYCLE, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MCYCLE, 13, 1'b0, 13);
    add_entry("meie_on", K_ACCESS, csr_pkg::CSR_OP_RS, csr_pkg::CSR_MIE, MIE_MASK, 1'b0, 0);
    add_entry("mie_on", K_ACCESS, csr_pkg::CSR_OP_RS, csr_pkg::CSR_MSTATUS, 32'h8, 1'b0, 0);
    add_entry("irq_trap", K_IRQ, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MEPC, 32'h1234, 1'b0, 0);
    add_entry("mret", K_MRET, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MSTATUS, 0, 1'b0, 0);
    add_entry("mie_off", K_ACCESS, csr_pkg::CSR_OP_RC, csr_pkg::CSR_MSTATUS, 32'h8, 1'b0, 0);
    add_entry("wfi_wake", K_WFI_WAKE, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MEPC, 0, 1'b0, 0);
    add_entry("mie_on_again", K_ACCESS, csr_pkg::CSR_OP_RS, csr_pkg::CSR_MSTATUS, 32'h8, 1'b0, 0);
    add_entry("wfi_trap", K_WFI_TRAP, csr_pkg::CSR_OP_RW, csr_pkg::CSR_MEPC, 32'h2040, 1'b0, 0);
  endtask

  task automatic read_csr(input string what, input logic [11:0] addr, input logic [31:0] exp);
    @(posedge clk);
    csr_addr <= addr;
    chk0.check_rdata(what, exp);
  endtask

  // Old value visible during the write cycle, new one after the edge
  task automatic access_csr(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                            input logic [31:0] src);
    @(posedge clk);
    csr_valid <= 1'b1;
    csr_op    <= op;
    csr_addr  <= addr;
    csr_src   <= src;
    chk0.check_rdata("old value", model_read(addr));
    @(posedge clk);
    csr_valid <= 1'b0;
    model_write(op, addr, src);
    chk0.check_rdata("readback", model_read(addr));
  endtask

  task automatic pulse_wfi();
    @(posedge clk);
    wfi <= 1'b1;
    @(posedge clk);
    wfi <= 1'b0;
  endtask

  task automatic clear_irq();
    @(posedge clk);
    irq      <= 1'b0;
    csr_addr <= csr_pkg::CSR_MIP;
    chk0.wait_rdata(32'd0, TIMEOUT);
  endtask

  task automatic run_entry(input int i);
    case (t_kind[i])
      K_ACCESS: access_csr(t_op[i], t_addr[i], t_rand[i] ? lcg_next() : t_src[i]);
      K_READ:   read_csr("read", t_addr[i], t_exp[i]);
      K_RETIRE: begin
        @(posedge clk);
        retire <= 1'b1;
        repeat (t_src[i]) @(posedge clk);
        retire <= 1'b0;
        read_csr("minstret", t_addr[i], t_exp[i]);
        read_csr("minstreth", csr_pkg::CSR_MINSTRETH, 32'd0);
      end
      K_CYCLE: begin
        @(posedge clk);
        csr_addr <= t_addr[i];
        chk0.check_cycle_delta(t_exp[i]);
      end
      K_IRQ: begin
        @(posedge clk);
        pc  <= t_src[i];
        irq <= 1'b1;
        chk0.wait_redirect(csr_pkg::MTVEC_BASE, TIMEOUT);
        model_trap(t_src[i]);
        read_csr("mepc", csr_pkg::CSR_MEPC, m_mepc);
        read_csr("mstatus", csr_pkg::CSR_MSTATUS, m_mstatus);
        read_csr("mip", csr_pkg::CSR_MIP, MEIP_BIT);
        clear_irq();
      end
      K_MRET: begin
        @(posedge clk);
        mret <= 1'b1;
        @(posedge clk);
        mret <= 1'b0;
        chk0.wait_redirect(m_mepc, TIMEOUT);
        model_mret();
        read_csr("mstatus", csr_pkg::CSR_MSTATUS, m_mstatus);
      end
      K_WFI_WAKE: begin
        pulse_wfi();
        chk0.check_stall(1'b1);
        @(posedge clk);
        irq <= 1'b1;
        chk0.wait_stall_low(TIMEOUT);
        chk0.watch_no_redirect(4);
        read_csr("mepc", csr_pkg::CSR_MEPC, m_mepc);
        clear_irq();
      end
      K_WFI_TRAP: begin
        @(posedge clk);
        pc <= t_src[i];
        pulse_wfi();
        chk0.check_stall(1'b1);
        @(posedge clk);
        irq <= 1'b1;
        chk0.wait_redirect(csr_pkg::MTVEC_BASE, TIMEOUT);
        model_trap(t_src[i] + 32'd4);  // Resumes after the WFI
        read_csr("mepc", csr_pkg::CSR_MEPC, m_mepc);
        read_csr("mstatus", csr_pkg::CSR_MSTATUS, m_mstatus);
        clear_irq();
      end
    endcase
  endtask

  initial begin
    csr_valid <= 1'b0;
    csr_op    <= csr_pkg::CSR_OP_RW;
    csr_addr  <= 12'h000;
    csr_src   <= 32'd0;
    pc        <= 32'd0;
    retire    <= 1'b0;
    mret      <= 1'b0;
    wfi       <= 1'b0;
    irq       <= 1'b0;
    load_table();
    chk0.wait_reset(10);
    for (int i = 0; i < t_name.size(); i++) begin
      chk0.start_test(t_name[i]);
      run_entry(i);
      chk0.finish_test();
    end
    chk0.report_counts();
    if (chk0.error_total == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/csr_checker.sv
`default_nettype none

module csr_checker (
  input wire logic        clk,
  input wire logic        rstn,
  input wire logic [31:0] rdata_i,
  input wire logic        redirect_i,
  input wire logic [31:0] redirect_pc_i,
  input wire logic        stall_i
);
  timeunit 1ns;
  timeprecision 100ps;

  string test_name    = "reset";
  int    test_errors  = 0;
  int    tests_run    = 0;
  int    tests_failed = 0;
  int    error_total  = 0;

  task automatic log_error(input string text);
    $display("ERROR %s: %s", test_name, text);
    test_errors++;
    error_total++;
  endtask

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s (%s): expected %h, actual %h", test_name, what, exp, act);
      test_errors++;
      error_total++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
      $display("FAIL %s, %0d errors", test_name, test_errors);
    end else begin
      $display("PASS %s", test_name);
    end
  endtask

  task automatic wait_reset(input int limit);
    int n;
    n = 0;
    while (rstn !== 1'b1 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (rstn !== 1'b1) begin
      log_error("reset was never released");
    end
  endtask

  // DUT outputs are settled by the falling edge
  task automatic check_rdata(input string what, input logic [31:0] exp);
    @(negedge clk);
    compare_value(what, exp, rdata_i);
  endtask

  task automatic check_stall(input logic exp);
    @(negedge clk);
    compare_value("stall", {31'd0, exp}, {31'd0, stall_i});
  endtask

  task automatic wait_rdata(input logic [31:0] exp, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (rdata_i !== exp && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (rdata_i !== exp) begin
      log_error($sformatf("read value did not reach %h within %0d cycles", exp, limit));
    end
  endtask

  task automatic wait_redirect(input logic [31:0] exp_pc, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (!redirect_i && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (redirect_i) begin
      compare_value("redirect pc", exp_pc, redirect_pc_i);
    end else begin
      log_error($sformatf("no redirect within %0d cycles", limit));
    end
  endtask

  task automatic wait_stall_low(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (stall_i && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (stall_i) begin
      log_error($sformatf("stall still high after %0d cycles", limit));
    end
  endtask

  task automatic watch_no_redirect(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (redirect_i) begin
        log_error("redirect seen after a wake without trap");
      end
    end
  endtask

  // Address must already point at mcycle
  task automatic check_cycle_delta(input logic [31:0] k);
    logic [31:0] first;
    @(negedge clk);
    first = rdata_i;
    repeat (k) @(negedge clk);
    compare_value("mcycle delta", k, rdata_i - first);
  endtask

  task automatic report_counts();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_total);
  endtask

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rstn
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // Reset held low over the first two rising edges
  initial begin
    rstn = 1'b0;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
  end

endmodule

`default_nettype wire

//--- verilog/csr_unit.sv
`default_nettype none

module csr_unit (
  input  wire logic                              clk,
  input  wire logic                              rstn,
  input  wire logic                              csr_valid_i,
  input  wire csr_pkg::csr_op_e                  csr_op_i,
  input  wire logic [csr_pkg::CSR_ADDR_W-1:0]    csr_addr_i,
  input  wire logic [csr_pkg::XLEN-1:0]          csr_src_i,
  input  wire logic [csr_pkg::XLEN-1:0]          pc_i,
  input  wire logic                              retire_i,
  input  wire logic                              mret_i,
  input  wire logic                              wfi_i,
  input  wire logic                              irq_i,
  output logic      [csr_pkg::XLEN-1:0]          csr_rdata_o,
  output logic                                   redirect_o,
  output logic      [csr_pkg::XLEN-1:0]          redirect_pc_o,
  output logic                                   stall_o
);

  logic                     wr_en;
  logic [csr_pkg::XLEN-1:0] wr_data;
  logic [csr_pkg::XLEN-1:0] mepc;
  logic                     irq_pending;
  logic                     mie;
  logic                     trap_take;
  logic                     trap_from_wait;

  // Old value for read-modify-write comes straight off the read mux
  csr_wdata_gen u_wdata_gen (
    .csr_valid_i (csr_valid_i),
    .csr_op_i    (csr_op_i),
    .csr_src_i   (csr_src_i),
    .old_i       (csr_rdata_o),
    .wr_en_o     (wr_en),
    .wr_data_o   (wr_data)
  );

  csr_regfile u_regfile (
    .clk              (clk),
    .rstn             (rstn),
    .csr_addr_i       (csr_addr_i),
    .wr_en_i          (wr_en),
    .wr_data_i        (wr_data),
    .pc_i             (pc_i),
    .retire_i         (retire_i),
    .irq_i            (irq_i),
    .trap_take_i      (trap_take),
    .trap_from_wait_i (trap_from_wait),
    .mret_i           (mret_i),
    .rdata_o          (csr_rdata_o),
    .mepc_o           (mepc),
    .irq_pending_o    (irq_pending),
    .mie_o            (mie)
  );

  trap_ctrl u_trap_ctrl (
    .clk              (clk),
    .rstn             (rstn),
    .wfi_i            (wfi_i),
    .mret_i           (mret_i),
    .irq_pending_i    (irq_pending),
    .mie_i            (mie),
    .mepc_i           (mepc),
    .trap_take_o      (trap_take),
    .trap_from_wait_o (trap_from_wait),
    .redirect_o       (redirect_o),
    .redirect_pc_o    (redirect_pc_o),
    .stall_o          (stall_o)
  );

endmodule

`default_nettype wire

//--- verilog/trap_ctrl.sv
`default_nettype none

module trap_ctrl (
  input  wire logic                        clk,
  input  wire logic                        rstn,
  input  wire logic                        wfi_i,
  input  wire logic                        mret_i,
  input  wire logic                        irq_pending_i,
  input  wire logic                        mie_i,
  input  wire logic [csr_pkg::XLEN-1:0]    mepc_i,
  output logic                             trap_take_o,
  output logic                             trap_from_wait_o,
  output logic                             redirect_o,
  output logic      [csr_pkg::XLEN-1:0]    redirect_pc_o,
  output logic                             stall_o
);

  csr_pkg::trap_state_e state_q;
  csr_pkg::trap_state_e state_d;
  logic [csr_pkg::XLEN-1:0] redirect_pc_q;

  // No trap during the redirect cycle, MRET wins
  assign trap_take_o = (state_q != csr_pkg::T_REDIRECT) && irq_pending_i && mie_i &&
                       !mret_i;
  assign trap_from_wait_o = (state_q == csr_pkg::T_WAIT);

  always_comb begin
    state_d = state_q;
    case (state_q)
      csr_pkg::T_RUN: begin
        if (mret_i || trap_take_o) begin
          state_d = csr_pkg::T_REDIRECT;
        end else if (wfi_i && !irq_pending_i) begin
          state_d = csr_pkg::T_WAIT;
        end
      end
      csr_pkg::T_WAIT: begin
        // Wake on any enabled pending interrupt, trap only with MIE set
        if (trap_take_o) begin
          state_d = csr_pkg::T_REDIRECT;
        end else if (irq_pending_i) begin
          state_d = csr_pkg::T_RUN;
        end
      end
      csr_pkg::T_REDIRECT: state_d = csr_pkg::T_RUN;
      default:             state_d = csr_pkg::T_RUN;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= csr_pkg::T_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // Target captured on the edge that enters T_REDIRECT
  always_ff @(posedge clk) begin
    if (state_q == csr_pkg::T_RUN && mret_i) begin
      redirect_pc_q <= mepc_i;  // Value before the MRET edge
    end else if (trap_take_o) begin
      redirect_pc_q <= csr_pkg::MTVEC_BASE;
    end
  end

  assign redirect_o    = (state_q == csr_pkg::T_REDIRECT);
  assign redirect_pc_o = redirect_pc_q;
  assign stall_o       = (state_q == csr_pkg::T_WAIT);

  // Redirect is a single-cycle pulse
  assert property (@(posedge clk) disable iff (!rstn) redirect_o |=> !redirect_o)
    else $error("redirect held for two cycles");

  assert property (@(posedge clk) disable iff (!rstn) !(stall_o && redirect_o))
    else $error("stall and redirect together");

endmodule

`default_nettype wire

//--- verilog/csr_regfile.sv
`default_nettype none

module csr_regfile (
  input  wire logic                              clk,
  input  wire logic                              rstn,
  input  wire logic [csr_pkg::CSR_ADDR_W-1:0]    csr_addr_i,
  input  wire logic                              wr_en_i,
  input  wire logic [csr_pkg::XLEN-1:0]          wr_data_i,
  input  wire logic [csr_pkg::XLEN-1:0]          pc_i,
  input  wire logic                              retire_i,
  input  wire logic                              irq_i,
  input  wire logic                              trap_take_i,
  input  wire logic                              trap_from_wait_i,
  input  wire logic                              mret_i,
  output logic      [csr_pkg::XLEN-1:0]          rdata_o,
  output logic      [csr_pkg::XLEN-1:0]          mepc_o,
  output logic                                   irq_pending_o,
  output logic                                   mie_o
);

  logic [csr_pkg::XLEN-1:0] mstatus_q;
  logic [csr_pkg::XLEN-1:0] mie_q;
  logic [csr_pkg::XLEN-1:0] mepc_q;
  logic [csr_pkg::XLEN-1:0] mip_val;
  logic [2*csr_pkg::XLEN-1:0] mcycle_q;    // {mcycleh, mcycle}
  logic [2*csr_pkg::XLEN-1:0] minstret_q;  // {minstreth, minstret}

  logic irq_meta_q;  // First synchronizer stage
  logic meip_q;      // Second stage is mip.MEIP

  logic wr_mstatus;
  logic wr_mie;
  logic wr_mepc;
  logic [csr_pkg::XLEN-1:0] trap_pc;

  // Write decode
  assign wr_mstatus = wr_en_i && (csr_addr_i == csr_pkg::CSR_MSTATUS);
  assign wr_mie     = wr_en_i && (csr_addr_i == csr_pkg::CSR_MIE);
  assign wr_mepc    = wr_en_i && (csr_addr_i == csr_pkg::CSR_MEPC);

  // WFI resumes after the wait instruction
  assign trap_pc = trap_from_wait_i ? pc_i + 32'd4 : pc_i;

  // mstatus, priority MRET then trap then write
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mstatus_q <= csr_pkg::CSR_ZERO;
    end else if (mret_i) begin
      mstatus_q[csr_pkg::MSTATUS_MIE]  <= mstatus_q[csr_pkg::MSTATUS_MPIE];
      mstatus_q[csr_pkg::MSTATUS_MPIE] <= 1'b1;
      mstatus_q[csr_pkg::MSTATUS_MPP +: csr_pkg::MSTATUS_MPP_W] <= 2'b11;
    end else if (trap_take_i) begin
      mstatus_q[csr_pkg::MSTATUS_MPIE] <= mstatus_q[csr_pkg::MSTATUS_MIE];
      mstatus_q[csr_pkg::MSTATUS_MIE]  <= 1'b0;
      mstatus_q[csr_pkg::MSTATUS_MPP +: csr_pkg::MSTATUS_MPP_W] <= 2'b11;
    end else if (wr_mstatus) begin
      // Only MIE, MPIE and MPP are implemented
      mstatus_q[csr_pkg::MSTATUS_MIE]  <= wr_data_i[csr_pkg::MSTATUS_MIE];
      mstatus_q[csr_pkg::MSTATUS_MPIE] <= wr_data_i[csr_pkg::MSTATUS_MPIE];
      mstatus_q[csr_pkg::MSTATUS_MPP +: csr_pkg::MSTATUS_MPP_W] <=
        wr_data_i[csr_pkg::MSTATUS_MPP +: csr_pkg::MSTATUS_MPP_W];
    end
  end

  // mie, external enable only
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mie_q <= csr_pkg::CSR_ZERO;
    end else if (wr_mie) begin
      mie_q[csr_pkg::MEIE] <= wr_data_i[csr_pkg::MEIE];
    end
  end

  // mepc, trap entry wins over a software write
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mepc_q <= csr_pkg::CSR_ZERO;
    end else if (trap_take_i) begin
      mepc_q <= {trap_pc[csr_pkg::XLEN-1:2], 2'b00};
    end else if (wr_mepc) begin
      mepc_q[csr_pkg::XLEN-1:2] <= wr_data_i[csr_pkg::XLEN-1:2];
    end
  end

  // Two-flop synchronizer for the external interrupt level
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      irq_meta_q <= 1'b0;
      meip_q     <= 1'b0;
    end else begin
      irq_meta_q <= irq_i;
      meip_q     <= irq_meta_q;
    end
  end

  // Free-running cycle counter and retire counter
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      mcycle_q <= mcycle_q + 64'd1;
      if (retire_i) begin
        minstret_q <= minstret_q + 64'd1;
      end
    end
  end

  always_comb begin
    mip_val                = csr_pkg::CSR_ZERO;
    mip_val[csr_pkg::MEIP] = meip_q;
  end

  // Read mux, ID registers fall into default and read zero
  always_comb begin
    case (csr_addr_i)
      csr_pkg::CSR_MSTATUS:   rdata_o = mstatus_q;
      csr_pkg::CSR_MIE:       rdata_o = mie_q;
      csr_pkg::CSR_MTVEC:     rdata_o = csr_pkg::MTVEC_BASE;
      csr_pkg::CSR_MEPC:      rdata_o = mepc_q;
      csr_pkg::CSR_MIP:       rdata_o = mip_val;
      csr_pkg::CSR_MCYCLE:    rdata_o = mcycle_q[csr_pkg::XLEN-1:0];
      csr_pkg::CSR_MCYCLEH:   rdata_o = mcycle_q[2*csr_pkg::XLEN-1:csr_pkg::XLEN];
      csr_pkg::CSR_MINSTRET:  rdata_o = minstret_q[csr_pkg::XLEN-1:0];
      csr_pkg::CSR_MINSTRETH: rdata_o = minstret_q[2*csr_pkg::XLEN-1:csr_pkg::XLEN];
      default:                rdata_o = csr_pkg::CSR_ZERO;
    endcase
  end

  assign mepc_o        = mepc_q;
  assign irq_pending_o = meip_q && mie_q[csr_pkg::MEIE];
  assign mie_o         = mstatus_q[csr_pkg::MSTATUS_MIE];

  // The trap controller must keep MRET and trap entry apart
  assert property (@(posedge clk) disable iff (!rstn) !(trap_take_i && mret_i))
    else $error("trap entry and MRET in the same cycle");

  // Covers both the trap path with a raw pc and the masked write path
  assert property (@(posedge clk) disable iff (!rstn) mepc_q[1:0] == 2'b00)
    else $error("mepc lost its alignment");

endmodule

`default_nettype wire

//--- verilog/csr_wdata_gen.sv
`default_nettype none

module csr_wdata_gen (
  input  wire logic                         csr_valid_i,
  input  wire csr_pkg::csr_op_e             csr_op_i,
  input  wire logic [csr_pkg::XLEN-1:0]     csr_src_i,
  input  wire logic [csr_pkg::XLEN-1:0]     old_i,
  output logic                              wr_en_o,
  output logic      [csr_pkg::XLEN-1:0]     wr_data_o
);

  logic src_zero;
  logic op_rw;
  logic op_set_clr;

  assign src_zero   = (csr_src_i == csr_pkg::CSR_ZERO);
  assign op_rw      = (csr_op_i == csr_pkg::CSR_OP_RW);
  assign op_set_clr = (csr_op_i == csr_pkg::CSR_OP_RS) ||
                      (csr_op_i == csr_pkg::CSR_OP_RC);

  // Set or clear with a zero source is a pure read
  assign wr_en_o = csr_valid_i && (op_rw || (op_set_clr && !src_zero));

  always_comb begin
    case (csr_op_i)
      csr_pkg::CSR_OP_RW: wr_data_o = csr_src_i;
      csr_pkg::CSR_OP_RS: wr_data_o = old_i | csr_src_i;
      csr_pkg::CSR_OP_RC: wr_data_o = old_i & ~csr_src_i;
      default:            wr_data_o = old_i;  // Unused encoding
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

  // Data and address widths
  localparam int XLEN       = 32;
  localparam int CSR_ADDR_W = 12;

  // Machine CSR addresses, standard encodings
  typedef enum logic [CSR_ADDR_W-1:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MIE       = 12'h304,
    CSR_MTVEC     = 12'h305,
    CSR_MEPC      = 12'h341,
    CSR_MIP       = 12'h344,
    CSR_MCYCLE    = 12'hB00,
    CSR_MINSTRET  = 12'hB02,
    CSR_MCYCLEH   = 12'hB80,
    CSR_MINSTRETH = 12'hB82,
    CSR_MVENDORID = 12'hF11,
    CSR_MARCHID   = 12'hF12,
    CSR_MIMPID    = 12'hF13,
    CSR_MHARTID   = 12'hF14
  } csr_addr_e;

  // Same values as funct3[1:0] of the register forms
  typedef enum logic [1:0] {
    CSR_OP_RW = 2'b01,
    CSR_OP_RS = 2'b10,
    CSR_OP_RC = 2'b11
  } csr_op_e;

  // mstatus fields
  localparam int MSTATUS_MIE   = 3;
  localparam int MSTATUS_MPIE  = 7;
  localparam int MSTATUS_MPP   = 11;
  localparam int MSTATUS_MPP_W = 2;

  // External interrupt bit in mie and mip
  localparam int MEIE = 11;
  localparam int MEIP = 11;

  // Direct mode only, so mtvec is a constant
  localparam logic [XLEN-1:0] MTVEC_BASE = 32'h0001_0000;

  localparam logic [XLEN-1:0] CSR_ZERO = '0;

  // Trap controller states
  typedef enum logic [1:0] {
    T_RUN      = 2'b00,  // Normal execution
    T_WAIT     = 2'b01,  // Parked in WFI
    T_REDIRECT = 2'b10   // One cycle of fetch redirect
  } trap_state_e;

endpackage

`default_nettype wire
